// File: cpu_pkg.sv
package cpu_pkg;

    // datapath and register index widths
    localparam int isa_width      = 32;
    localparam int reg_addr_width = 5;

    // instruction field widths
    localparam int opcode_width = 6;
    localparam int funct_width  = 6;
    localparam int shamt_width  = 5;
    localparam int imm_width    = 16;
    localparam int alu_op_width = 4;

    // field positions, counted down from the opcode
    localparam int rs_lsb    = isa_width - opcode_width - reg_addr_width;
    localparam int rt_lsb    = rs_lsb - reg_addr_width;
    localparam int rd_lsb    = rt_lsb - reg_addr_width;
    localparam int shamt_lsb = rd_lsb - shamt_width;

    // major opcodes, bits [31:26]
    typedef enum logic [opcode_width-1:0] {
        op_special = 6'h00,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f
    } opcode_e;

    // r-type function codes, bits [5:0]
    typedef enum logic [funct_width-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    // add/sub never trap, so signed and unsigned forms share one op
    typedef enum logic [alu_op_width-1:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_nor  = 4'h5,
        alu_slt  = 4'h6,
        alu_sltu = 4'h7,
        alu_sll  = 4'h8,
        alu_srl  = 4'h9,
        alu_sra  = 4'ha,
        alu_lui  = 4'hb
    } alu_op_e;

    // decode to execute, 86 bits
    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic [isa_width-1:0]      operand_a;
        logic [isa_width-1:0]      operand_b;
        logic [reg_addr_width-1:0] src_a_idx;
        logic [reg_addr_width-1:0] src_b_idx;
        // operand came from a register, so it may need forwarding
        logic                      use_a;
        logic                      use_b;
        logic [reg_addr_width-1:0] dest;
    } id_ex_t;

    // register write-back, 38 bits
    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] dest;
        logic [isa_width-1:0]      data;
    } wb_t;

endpackage

// File: register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int reg_count = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_idx,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_idx,
    output logic [cpu_pkg::isa_width-1:0]      rs_data,
    output logic [cpu_pkg::isa_width-1:0]      rt_data,
    input  cpu_pkg::wb_t                       wb
);
    import cpu_pkg::*;

    localparam int idx_width = $clog2(reg_count);
    localparam logic [reg_addr_width:0] reg_limit = (reg_addr_width + 1)'(reg_count);

    logic [isa_width-1:0] regs [reg_count];

    function automatic logic in_range(input logic [reg_addr_width-1:0] idx);
        return {1'b0, idx} < reg_limit;
    endfunction

    // r0 reads zero, a same-cycle write passes straight through
    function automatic logic [isa_width-1:0] read_port(input logic [reg_addr_width-1:0] idx);
        if (idx == '0 || !in_range(idx)) begin
            return '0;
        end else if (wb.valid && wb.dest == idx) begin
            return wb.data;
        end
        return regs[idx[idx_width-1:0]];
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && in_range(wb.dest)) begin
            regs[wb.dest[idx_width-1:0]] <= wb.data;
        end
    end

    // execute must never address a register this file does not hold
    assert property (@(posedge clk) disable iff (rst) wb.valid |-> in_range(wb.dest));

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpu_pkg::isa_width-1:0]      instruction,
    input  logic                               no_op,
    output logic [cpu_pkg::reg_addr_width-1:0] rs_idx,
    output logic [cpu_pkg::reg_addr_width-1:0] rt_idx,
    input  logic [cpu_pkg::isa_width-1:0]      rs_data,
    input  logic [cpu_pkg::isa_width-1:0]      rt_data,
    output cpu_pkg::id_ex_t                    id_ex
);
    import cpu_pkg::*;

    // if/id register
    logic                 if_id_valid;
    logic [isa_width-1:0] if_id_instruction;

    opcode_e                   op;
    funct_e                    funct;
    logic [reg_addr_width-1:0] rd;
    logic [shamt_width-1:0]    shamt;
    logic [imm_width-1:0]      imm;
    logic [isa_width-1:0]      imm_ext;

    logic                      known;
    logic                      r_type;
    logic                      shift;
    logic                      sign_ext;
    alu_op_e                   alu_op;
    logic [reg_addr_width-1:0] dest;
    id_ex_t                    id_ex_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= !no_op;
        end
        if_id_instruction <= instruction;
    end

    // field split
    assign op     = opcode_e'(if_id_instruction[isa_width-1 -: opcode_width]);
    assign funct  = funct_e'(if_id_instruction[funct_width-1:0]);
    assign rs_idx = if_id_instruction[rs_lsb +: reg_addr_width];
    assign rt_idx = if_id_instruction[rt_lsb +: reg_addr_width];
    assign rd     = if_id_instruction[rd_lsb +: reg_addr_width];
    assign shamt  = if_id_instruction[shamt_lsb +: shamt_width];
    assign imm    = if_id_instruction[imm_width-1:0];

    always_comb begin
        known    = 1'b1;
        r_type   = 1'b0;
        sign_ext = 1'b0;
        alu_op   = alu_add;
        case (op)
            op_special: begin
                r_type = 1'b1;
                case (funct)
                    fn_add, fn_addu: alu_op = alu_add;
                    fn_sub, fn_subu: alu_op = alu_sub;
                    fn_and:          alu_op = alu_and;
                    fn_or:           alu_op = alu_or;
                    fn_xor:          alu_op = alu_xor;
                    fn_nor:          alu_op = alu_nor;
                    fn_slt:          alu_op = alu_slt;
                    fn_sltu:         alu_op = alu_sltu;
                    fn_sll:          alu_op = alu_sll;
                    fn_srl:          alu_op = alu_srl;
                    fn_sra:          alu_op = alu_sra;
                    default:         known = 1'b0;
                endcase
            end
            op_addi, op_addiu: begin
                alu_op   = alu_add;
                sign_ext = 1'b1;
            end
            op_slti: begin
                alu_op   = alu_slt;
                sign_ext = 1'b1;
            end
            op_sltiu: begin
                // immediate is sign-extended, compare is unsigned
                alu_op   = alu_sltu;
                sign_ext = 1'b1;
            end
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_lui:  alu_op = alu_lui;
            default: known = 1'b0;
        endcase
    end

    assign shift   = r_type && (alu_op inside {alu_sll, alu_srl, alu_sra});
    assign dest    = r_type ? rd : rt_idx;
    assign imm_ext = sign_ext ? {{(isa_width - imm_width){imm[imm_width-1]}}, imm}
                              : {{(isa_width - imm_width){1'b0}}, imm};

    // operand selection
    always_comb begin
        id_ex_next.valid     = if_id_valid && known && dest != '0;
        id_ex_next.alu_op    = alu_op;
        id_ex_next.src_a_idx = rs_idx;
        id_ex_next.src_b_idx = rt_idx;
        id_ex_next.dest      = dest;
        // shifts take shamt on a, lui ignores rs
        id_ex_next.use_a     = !shift && op != op_lui;
        id_ex_next.use_b     = r_type;
        if (shift) begin
            id_ex_next.operand_a = {{(isa_width - shamt_width){1'b0}}, shamt};
        end else begin
            id_ex_next.operand_a = rs_data;
        end
        id_ex_next.operand_b = r_type ? rt_data : imm_ext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

    // an r0 destination must not reach execute as a valid write
    assert property (@(posedge clk) disable iff (rst) id_ex.valid |-> id_ex.dest != '0);

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e                alu_op,
    input  logic [cpu_pkg::isa_width-1:0]   a,
    input  logic [cpu_pkg::isa_width-1:0]   b,
    output logic [cpu_pkg::isa_width-1:0]   result
);
    import cpu_pkg::*;

    logic [shamt_width-1:0] shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    // shift amount is the low bits of a
    assign shamt       = a[shamt_width-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {{(isa_width - 1){1'b0}}, lt_signed};
            alu_sltu: result = {{(isa_width - 1){1'b0}}, lt_unsigned};
            alu_sll:  result = b << shamt;
            alu_srl:  result = b >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = $signed(b) >>> shamt;
            // immediate into the upper half
            alu_lui:  result = {b[imm_width-1:0], {(isa_width - imm_width){1'b0}}};
            default:  result = '0;
        endcase
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::wb_t    wb
);
    import cpu_pkg::*;

    logic                 fwd_a;
    logic                 fwd_b;
    logic [isa_width-1:0] alu_a;
    logic [isa_width-1:0] alu_b;
    logic [isa_width-1:0] alu_result;

    // forward from the instruction one ahead, now sitting in wb
    assign fwd_a = wb.valid && id_ex.use_a && id_ex.src_a_idx == wb.dest;
    assign fwd_b = wb.valid && id_ex.use_b && id_ex.src_b_idx == wb.dest;

    assign alu_a = fwd_a ? wb.data : id_ex.operand_a;
    assign alu_b = fwd_b ? wb.data : id_ex.operand_b;

    alu u_alu (
        .alu_op (id_ex.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // ex/wb register, also the register file write port
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= id_ex.valid;
        end
        wb.dest <= id_ex.dest;
        wb.data <= alu_result;
    end

    // decode filters r0, so a valid write-back always names a real register
    assert property (@(posedge clk) disable iff (rst) wb.valid |-> wb.dest != '0);

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int reg_count = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpu_pkg::isa_width-1:0] instruction,
    input  logic                          no_op,
    output cpu_pkg::wb_t                  wb
);
    import cpu_pkg::*;

    logic [reg_addr_width-1:0] rs_idx;
    logic [reg_addr_width-1:0] rt_idx;
    logic [isa_width-1:0]      rs_data;
    logic [isa_width-1:0]      rt_data;
    id_ex_t                    id_ex;

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .no_op       (no_op),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .id_ex       (id_ex)
    );

    register_file #(
        .reg_count (reg_count)
    ) u_register_file (
        .clk     (clk),
        .rst     (rst),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    execute_stage u_execute_stage (
        .clk   (clk),
        .rst   (rst),
        .id_ex (id_ex),
        .wb    (wb)
    );

endmodule

// File: tb_cpu_model.svh
`ifndef tb_cpu_model_svh
`define tb_cpu_model_svh

logic [31:0] rand_state;
logic [31:0] model_regs [32];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rand_state = xorshift32(rand_state);
    return rand_state;
endfunction

// applies one issued instruction in program order
task automatic model_issue(input logic [31:0] instr, input logic idle, output wb_t expected);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [4:0]  dest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] res;
    logic        known;
    op    = instr[31:26];
    rs    = instr[25:21];
    rt    = instr[20:16];
    rd    = instr[15:11];
    sh    = instr[10:6];
    fn    = instr[5:0];
    a     = model_regs[rs];
    b     = model_regs[rt];
    se    = {{16{instr[15]}}, instr[15:0]};
    ze    = {16'h0000, instr[15:0]};
    known = 1'b1;
    res   = '0;
    if (op == op_special) begin
        case (fn)
            fn_add, fn_addu: res = a + b;
            fn_sub, fn_subu: res = a - b;
            fn_and:          res = a & b;
            fn_or:           res = a | b;
            fn_xor:          res = a ^ b;
            fn_nor:          res = ~(a | b);
            fn_slt:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sltu:         res = (a < b) ? 32'd1 : 32'd0;
            fn_sll:          res = b << sh;
            fn_srl:          res = b >> sh;
            fn_sra:          res = $signed(b) >>> sh;
            default:         known = 1'b0;
        endcase
        dest = rd;
    end else begin
        case (op)
            op_addi, op_addiu: res = a + se;
            op_slti:           res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            op_sltiu:          res = (a < se) ? 32'd1 : 32'd0;
            op_andi:           res = a & ze;
            op_ori:            res = a | ze;
            op_xori:           res = a ^ ze;
            op_lui:            res = {instr[15:0], 16'h0000};
            default:           known = 1'b0;
        endcase
        dest = rt;
    end
    expected.valid = !idle && known && (dest != 5'd0);
    expected.dest  = dest;
    expected.data  = res;
    if (expected.valid) begin
        model_regs[dest] = res;
    end
endtask

`endif

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 16;
    localparam int stream_length = 2000;
    localparam int latency       = 3;
    // stream plus reset plus drain, with some slack
    localparam int max_cycles    = 2100;

    localparam logic [5:0] r_functs [13] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
        fn_xor, fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
    localparam logic [5:0] i_opcodes [8] = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi,
        op_ori, op_xori, op_lui};

    logic        clk;
    logic        rst;
    logic        no_op;
    logic [31:0] instruction;
    wb_t         wb;

    int  tick;
    int  cycle_count;
    int  checked;
    int  mismatches;
    int  other_errors;
    int  exp_due [$];
    wb_t exp_wb [$];

    `include "tb_cpu_model.svh"

    cpu_top #(
        .reg_count (32)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .no_op       (no_op),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > max_cycles) begin
                other_errors++;
                $display("timeout after %0d cycles, the stream did not finish", max_cycles);
                $display("summary: %0d checks, %0d mismatches, %0d other errors",
                         checked, mismatches, other_errors);
                $display("FAIL: see errors above");
                $finish;
            end
        end
    end

    // mostly r0..r3 so dependencies are dense
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[3:0] < 4'd13) begin
            return {3'b000, r[5:4]};
        end
        return r[12:8];
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [31:0] r;
        logic [31:0] bits;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        int          kind;
        r    = next_rand();
        bits = next_rand();
        kind = int'(r % 32'd24);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        sh   = bits[20:16];
        if (kind < 13) begin
            // shamt only for the three shifts
            if (kind < 10) begin
                sh = '0;
            end
            return {6'h00, rs, rt, rd, sh, r_functs[kind]};
        end else if (kind < 21) begin
            return {i_opcodes[kind-13], rs, rt, bits[15:0]};
        end else if (kind == 21) begin
            return {6'(op_ori), rs, rt, bits[15:0]};
        end else if (kind == 22) begin
            return {6'(op_lui), rs, rt, bits[15:0]};
        end
        // unknown opcode or funct, must act as a no-op
        if (r[5]) begin
            return {6'h23, rs, rt, bits[15:0]};
        end
        return {6'h00, rs, rt, rd, 5'h00, 6'h3f};
    endfunction

    task automatic check_output();
        wb_t exp;
        if (exp_due.size() > 0 && exp_due[0] == tick) begin
            exp = exp_wb.pop_front();
            void'(exp_due.pop_front());
        end else begin
            exp = '0;
        end
        checked++;
        assert (wb.valid === exp.valid) else begin
            mismatches++;
            $display("mismatch at %0t: wb.valid expected %b, got %b", $time, exp.valid, wb.valid);
        end
        if (exp.valid) begin
            assert (wb.dest === exp.dest) else begin
                mismatches++;
                $display("mismatch at %0t: wb.dest expected %0d, got %0d",
                         $time, exp.dest, wb.dest);
            end
            assert (wb.data === exp.data) else begin
                mismatches++;
                $display("mismatch at %0t: wb.data expected %h, got %h",
                         $time, exp.data, wb.data);
            end
        end
    endtask

    // outputs are checked before new inputs go in
    task automatic drive_cycle(input logic rst_level, input logic idle, input logic [31:0] instr);
        wb_t exp;
        @(negedge clk);
        check_output();
        rst         = rst_level;
        no_op       = idle;
        instruction = instr;
        if (!rst_level) begin
            model_issue(instr, idle, exp);
            exp_due.push_back(tick + latency);
            exp_wb.push_back(exp);
        end
        tick++;
    endtask

    initial begin
        logic [31:0] r;
        rst          = 1'b1;
        no_op        = 1'b1;
        instruction  = '0;
        rand_state   = 32'hcba6_15de;
        tick         = 0;
        checked      = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // the first rising edge also sees rst high
        for (int i = 0; i < reset_cycles - 1; i++) begin
            drive_cycle(1'b1, 1'b1, '0);
        end
        for (int i = 0; i < stream_length; i++) begin
            r = next_rand();
            drive_cycle(1'b0, (r % 32'd100) < 32'd15, random_instruction());
        end
        for (int i = 0; i < latency; i++) begin
            @(negedge clk);
            check_output();
            no_op = 1'b1;
            tick++;
        end
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
cpu_pkg.sv
register_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
cpu_top.sv
tb_cpu_top.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_cpu_top
RTL_TOP    ?= cpu_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
